// ==== include/video_consts.svh ====
// ####################
// Video colour constants
// Palette size, screen geometry and pipeline depths
// ####################

`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Palette address width, 512 colours of two bytes each
`define PAL_AW      10
`define PAL_DEPTH   (1 << `PAL_AW)

// Screen geometry in pixels and lines
`define H_TOTAL     32
`define H_ACTIVE    24
`define V_TOTAL     16
`define V_ACTIVE    12

// Pixel stages inside the blanking delay
`define BLANK_DLY   3
// Pixels from layer sampling to colour output
`define COLOUR_DLY  4

`endif

// ==== source/video_timing_pkg.sv ====
// ####################
// Video timing types
// Screen counter widths
// ####################

`include "video_consts.svh"

package video_timing_pkg;

    // Horizontal pixel counter
    typedef logic [$clog2(`H_TOTAL)-1:0] hcount_t;

    // Line counter
    typedef logic [$clog2(`V_TOTAL)-1:0] vcount_t;

endpackage

// ==== source/colour_pkg.sv ====
// ####################
// Colour types
// Palette entry views and layer pixel codes
// ####################

package colour_pkg;

    // 15-bit colour, blue on top
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } colour_t;

    // Entry as the CPU sees it, odd byte on top
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } pal_bytes_t;

    // Entry as the video side sees it
    typedef struct packed {
        logic    spare;
        colour_t rgb;
    } pal_colour_t;

    typedef union packed {
        pal_bytes_t  bytes;
        pal_colour_t col;
    } pal_entry_t;

    // Layer pixel code and palette bank
    typedef logic [6:0] layer_pxl_t;
    typedef logic [3:0] layer_pal_t;

endpackage

// ==== source/video_timing.sv ====
// ####################
// Video timing generator
// Pixel strobe plus horizontal and vertical blanking
// ####################

`timescale 1ns/1ps
`include "video_consts.svh"

module video_timing (
    input  logic clk,
    input  logic rst,
    output logic pxl_cen,
    output logic LHBL,
    output logic LVBL
);

    video_timing_pkg::hcount_t hcnt;
    video_timing_pkg::hcount_t hcnt_nx;
    video_timing_pkg::vcount_t vcnt;
    video_timing_pkg::vcount_t vcnt_nx;
    logic                      h_wrap;
    logic                      v_wrap;

    // End of line and end of frame
    assign h_wrap = hcnt == video_timing_pkg::hcount_t'(`H_TOTAL - 1);
    assign v_wrap = vcnt == video_timing_pkg::vcount_t'(`V_TOTAL - 1);

    // Next counter values
    always_comb begin
        hcnt_nx = h_wrap ? '0 : hcnt + 1'b1;
        vcnt_nx = vcnt;
        if (h_wrap) begin
            vcnt_nx = v_wrap ? '0 : vcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            hcnt    <= '0;
            vcnt    <= '0;
            LHBL    <= 1'b0;
            LVBL    <= 1'b0;
        end else begin
            // Divide by two
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                hcnt <= hcnt_nx;
                vcnt <= vcnt_nx;
                // Blanks follow the new count
                LHBL <= hcnt_nx < `H_ACTIVE;
                LVBL <= vcnt_nx < `V_ACTIVE;
            end
        end
    end

endmodule

// ==== source/palette_ram.sv ====
// ####################
// Palette memory
// 1 KB dual port, CPU byte port and video read port
// ####################

`timescale 1ns/1ps
`include "video_consts.svh"

module palette_ram (
    input  logic              clk,
    input  logic              we,
    input  logic [`PAL_AW-1:0] cpu_addr,
    input  logic [7:0]        cpu_din,
    input  logic [`PAL_AW-1:0] vid_addr,
    output logic [7:0]        cpu_q,
    output logic [7:0]        vid_q
);

    logic [7:0] mem [0:`PAL_DEPTH-1];

    // CPU port, read before write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_q <= mem[cpu_addr];
    end

    // Video port, read only
    // Same-address write in this clock leaves the old byte here
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

// ==== source/colour_mixer.sv ====
// ####################
// Colour mixer
// Layer priority, two palette byte reads per pixel
// and 15-bit colour assembly
// ####################

`timescale 1ns/1ps
`include "video_consts.svh"

module colour_mixer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  colour_pkg::layer_pxl_t gfx1_pxl,
    input  colour_pkg::layer_pal_t gfx1_pal,
    input  colour_pkg::layer_pxl_t gfx2_pxl,
    input  colour_pkg::layer_pal_t gfx2_pal,
    input  logic [7:0]             pal_q,
    output logic [`PAL_AW-1:0]     pal_addr,
    output colour_pkg::colour_t    col
);

    logic                   gfx1_blank;
    colour_pkg::layer_pxl_t win_pxl;
    colour_pkg::layer_pal_t win_pal;
    logic                   half;
    colour_pkg::pal_entry_t entry;

    // gfx1 is transparent when its low nibble is zero
    assign gfx1_blank = gfx1_pxl[3:0] == 4'h0;

    // Winner, gfx2 looked up even when blank too
    assign win_pxl = gfx1_blank ? gfx2_pxl : gfx1_pxl;
    assign win_pal = gfx1_blank ? gfx2_pal : gfx1_pal;

    // Pixel bit 4, bank, pixel nibble, byte select
    assign pal_addr = {win_pxl[4], win_pal, win_pxl[3:0], half};

    // Half sequencer
    // Odd byte is read on the clock after pxl_cen, even byte on the next
    always_ff @(posedge clk) begin
        if (rst) begin
            half <= 1'b0;
            col  <= '0;
        end else begin
            if (pxl_cen) begin
                half <= 1'b1;
                // Both bytes of the previous pixel are in by now
                col  <= entry.col.rgb;
            end else begin
                half <= ~half;
            end
        end
    end

    // Byte assembly
    // Odd byte arrives first and ends up on top
    always_ff @(posedge clk) begin
        entry.bytes <= {entry.bytes.lo, pal_q};
    end

endmodule

// ==== source/blank_delay.sv ====
// ####################
// Blanking delay
// Aligns colour with delayed blanks and blacks out
// the blanked pixels
// ####################

`timescale 1ns/1ps
`include "video_consts.svh"

module blank_delay (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  logic                LHBL,
    input  logic                LVBL,
    input  colour_pkg::colour_t col_in,
    output logic                LHBL_dly,
    output logic                LVBL_dly,
    output colour_pkg::colour_t col_out
);

    // Blanks come in one pixel ahead of the mixer colour,
    // so they run one stage deeper
    logic [`COLOUR_DLY-1:0] lhbl_sr;
    logic [`COLOUR_DLY-1:0] lvbl_sr;
    colour_pkg::colour_t    col_sr [`BLANK_DLY];

    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
            for (int i = 0; i < `BLANK_DLY; i++) begin
                col_sr[i] <= '0;
            end
        end else if (pxl_cen) begin
            lhbl_sr   <= {lhbl_sr[`COLOUR_DLY-2:0], LHBL};
            lvbl_sr   <= {lvbl_sr[`COLOUR_DLY-2:0], LVBL};
            col_sr[0] <= col_in;
            for (int i = 1; i < `BLANK_DLY; i++) begin
                col_sr[i] <= col_sr[i-1];
            end
        end
    end

    assign LHBL_dly = lhbl_sr[`COLOUR_DLY-1];
    assign LVBL_dly = lvbl_sr[`COLOUR_DLY-1];

    // Black outside the active area
    assign col_out = (LHBL_dly && LVBL_dly) ? col_sr[`BLANK_DLY-1] : '0;

endmodule

// ==== source/video_colour_top.sv ====
// ####################
// Video colour stage
// Timing, palette RAM, colour mixer and blanking delay
// ####################

`timescale 1ns/1ps
`include "video_consts.svh"

module video_colour_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pal_cs,
    input  logic                   cpu_rnw,
    input  logic                   cpu_cen,
    input  logic [`PAL_AW-1:0]     cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  colour_pkg::layer_pxl_t gfx1_pxl,
    input  colour_pkg::layer_pal_t gfx1_pal,
    input  colour_pkg::layer_pxl_t gfx2_pxl,
    input  colour_pkg::layer_pal_t gfx2_pal,
    output logic [7:0]             pal_dout,
    output logic                   pxl_cen,
    output logic                   LHBL,
    output logic                   LVBL,
    output logic                   LHBL_dly,
    output logic                   LVBL_dly,
    output logic [4:0]             red,
    output logic [4:0]             green,
    output logic [4:0]             blue
);

    logic                pal_we;
    logic [`PAL_AW-1:0]  vid_addr;
    logic [7:0]          vid_q;
    colour_pkg::colour_t col_mix;
    colour_pkg::colour_t col_out;

    // CPU write strobe
    assign pal_we = cpu_cen & pal_cs & ~cpu_rnw;

    video_timing video_timing_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .LHBL    (LHBL),
        .LVBL    (LVBL)
    );

    palette_ram palette_ram_i (
        .clk      (clk),
        .we       (pal_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_dout),
        .vid_addr (vid_addr),
        .cpu_q    (pal_dout),
        .vid_q    (vid_q)
    );

    colour_mixer colour_mixer_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx1_pxl (gfx1_pxl),
        .gfx1_pal (gfx1_pal),
        .gfx2_pxl (gfx2_pxl),
        .gfx2_pal (gfx2_pal),
        .pal_q    (vid_q),
        .pal_addr (vid_addr),
        .col      (col_mix)
    );

    blank_delay blank_delay_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .col_in   (col_mix),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .col_out  (col_out)
    );

    // Colour components out
    assign red   = col_out.red;
    assign green = col_out.green;
    assign blue  = col_out.blue;

endmodule

// ==== bench/clock_gen.sv ====
// ####################
// Testbench clock and reset
// ####################

`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released a little after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

// ==== bench/video_colour_tb.sv ====
// ####################
// Video colour stage testbench
// Palette load and readback followed by three frames of
// layer pixels checked against a reference model
// ####################

`timescale 1ns/1ps
`include "video_consts.svh"

module video_colour_tb;

    localparam int LOAD_CLOCKS  = 2 * `PAL_DEPTH + 16;
    localparam int VIDEO_PIXELS = 3 * `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT      = 2 * (LOAD_CLOCKS + 2 * VIDEO_PIXELS + 16);

    // Expected values of one pixel
    typedef struct packed {
        logic                skip;
        logic                lhbl;
        logic                lvbl;
        colour_pkg::colour_t col;
    } pixel_exp_t;

    logic                   clk;
    logic                   rst;
    logic                   pal_cs;
    logic                   cpu_rnw;
    logic                   cpu_cen;
    logic [`PAL_AW-1:0]     cpu_addr;
    logic [7:0]             cpu_dout;
    colour_pkg::layer_pxl_t gfx1_pxl;
    colour_pkg::layer_pal_t gfx1_pal;
    colour_pkg::layer_pxl_t gfx2_pxl;
    colour_pkg::layer_pal_t gfx2_pal;
    logic [7:0]             pal_dout;
    logic                   pxl_cen;
    logic                   LHBL;
    logic                   LVBL;
    logic                   LHBL_dly;
    logic                   LVBL_dly;
    logic [4:0]             red;
    logic [4:0]             green;
    logic [4:0]             blue;

    // Mirror of every palette write
    logic [7:0]  mirror [0:`PAL_DEPTH-1];
    pixel_exp_t  exp_q [$];
    logic [16:0] lfsr_state = 17'd88841;
    logic        skip_next  = 1'b0;
    logic        cen_exp    = 1'b0;
    int          pix_cnt    = 0;
    int          clk_cnt    = 0;
    int          err_pal    = 0;
    int          err_col    = 0;
    int          err_blank  = 0;

    clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    video_colour_top video_colour_top_i (
        .clk      (clk),
        .rst      (rst),
        .pal_cs   (pal_cs),
        .cpu_rnw  (cpu_rnw),
        .cpu_cen  (cpu_cen),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .gfx1_pxl (gfx1_pxl),
        .gfx1_pal (gfx1_pal),
        .gfx2_pxl (gfx2_pxl),
        .gfx2_pal (gfx2_pal),
        .pal_dout (pal_dout),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    // 17-bit Fibonacci LFSR with taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // One step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Even byte address of the winning layer
    // gfx1 loses when its low nibble is zero
    function automatic logic [`PAL_AW-1:0] pal_base(input logic [6:0] p1, input logic [3:0] b1,
                                                    input logic [6:0] p2, input logic [3:0] b2);
        logic [6:0] p;
        logic [3:0] b;
        p = (p1[3:0] != 4'h0) ? p1 : p2;
        b = (p1[3:0] != 4'h0) ? b1 : b2;
        return {p[4], b, p[3:0], 1'b0};
    endfunction

    // Colour from the mirror
    // Odd byte gives bits 14..8
    function automatic colour_pkg::colour_t colour_ref(input logic [`PAL_AW-1:0] base);
        return {mirror[base | 1][6:0], mirror[base]};
    endfunction

    // Blanks after pixel strobe j
    // Both low before the first strobe
    function automatic logic [1:0] blank_ref(input int j);
        if (j == 0) begin
            return 2'b00;
        end
        return {(j % `H_TOTAL) < `H_ACTIVE, ((j / `H_TOTAL) % `V_TOTAL) < `V_ACTIVE};
    endfunction

    task automatic next_clock();
        @(posedge clk);
        #10;
    endtask

    // Ends 10 ns after the next edge that carries pxl_cen
    task automatic next_pixel();
        @(negedge clk);
        while (!pxl_cen) begin
            @(negedge clk);
        end
        next_clock();
    endtask

    task automatic cpu_write(input logic [`PAL_AW-1:0] a, input logic [7:0] d);
        pal_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        cpu_cen   = 1'b1;
        cpu_addr  = a;
        cpu_dout  = d;
        mirror[a] = d;
        next_clock();
        pal_cs  = 1'b0;
        cpu_rnw = 1'b1;
        cpu_cen = 1'b0;
    endtask

    // Half of the gfx1 codes are blank with code 16 among them
    task automatic drive_layers();
        case (rand_bits(2))
            0:       gfx1_pxl = {3'(rand_bits(3)), 4'h0};
            1:       gfx1_pxl = 7'h10;
            default: gfx1_pxl = 7'(rand_bits(7));
        endcase
        gfx1_pal = 4'(rand_bits(4));
        gfx2_pxl = 7'(rand_bits(7));
        gfx2_pal = 4'(rand_bits(4));
    endtask

    task automatic check_colour(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            err_col++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        pixel_exp_t pe;
        logic [1:0] bl;
        logic       hold;
        hold     = 1'b0;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        gfx1_pxl = '0;
        gfx1_pal = '0;
        gfx2_pxl = '0;
        gfx2_pal = '0;
        @(negedge rst);
        next_clock();

        // Fill the whole palette
        for (int a = 0; a < `PAL_DEPTH; a++) begin
            cpu_write(a[`PAL_AW-1:0], 8'(rand_bits(8)));
        end

        // Readback with data one clock after the address
        for (int a = 0; a <= `PAL_DEPTH; a++) begin
            if (a > 0 && pal_dout !== mirror[a-1]) begin
                err_pal++;
                $display("** Error: pal_dout at %h got %h expected %h", a - 1, pal_dout,
                         mirror[a-1]);
            end
            cpu_addr = a[`PAL_AW-1:0];
            next_clock();
        end

        // Three frames of layer pixels
        next_pixel();
        drive_layers();
        for (int n = 0; n < VIDEO_PIXELS; n++) begin
            next_pixel();
            bl = blank_ref(pix_cnt);
            if ({LHBL, LVBL} !== bl) begin
                err_blank++;
                $display("** Error: LHBL,LVBL got %h expected %h", {LHBL, LVBL}, bl);
            end
            pe.skip = skip_next;
            pe.lhbl = bl[1];
            pe.lvbl = bl[0];
            pe.col  = colour_ref(pal_base(gfx1_pxl, gfx1_pal, gfx2_pxl, gfx2_pal));
            exp_q.push_back(pe);
            skip_next = 1'b0;
            if (hold) begin
                hold = 1'b0;
            end else begin
                drive_layers();
                if (n % 16 == 15) begin
                    // Lookup of this pixel straddles the write
                    // The next pixel repeats it and must see the new byte
                    cpu_write(pal_base(gfx1_pxl, gfx1_pal, gfx2_pxl, gfx2_pal)
                              | `PAL_AW'(rand_bits(1)), 8'(rand_bits(8)));
                    skip_next = 1'b1;
                    hold      = 1'b1;
                end
            end
        end

        $display("Errors: palette %0d, colour %0d, blanking %0d", err_pal, err_col, err_blank);
        if (err_pal + err_col + err_blank == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Compare half a clock after each edge
    // Also counts pixel strobes
    // pix_cnt names the strobe edge that comes next
    always @(negedge clk) begin : compare_outputs
        pixel_exp_t ce;
        // Strobe on every second clock, low on the first clock after reset
        if (pxl_cen !== cen_exp) begin
            err_blank++;
            $display("** Error: pxl_cen got %h expected %h", pxl_cen, cen_exp);
        end
        // Raw blanks held low in reset
        if (rst && {LHBL, LVBL} !== 2'b00) begin
            err_blank++;
            $display("** Error: LHBL,LVBL in reset got %h expected 0", {LHBL, LVBL});
        end
        cen_exp = rst ? 1'b0 : ~cen_exp;
        // Nothing leaves the pipeline while it fills
        if (pix_cnt <= `COLOUR_DLY && {red, green, blue, LHBL_dly, LVBL_dly} !== '0) begin
            err_col++;
            $display("** Error: red,green,blue,LHBL_dly,LVBL_dly during fill got %h expected 0",
                     {red, green, blue, LHBL_dly, LVBL_dly});
        end
        if (exp_q.size() > `COLOUR_DLY) begin
            ce = exp_q.pop_front();
            if (LHBL_dly !== ce.lhbl) begin
                err_blank++;
                $display("** Error: LHBL_dly got %h expected %h", LHBL_dly, ce.lhbl);
            end
            if (LVBL_dly !== ce.lvbl) begin
                err_blank++;
                $display("** Error: LVBL_dly got %h expected %h", LVBL_dly, ce.lvbl);
            end
            // Blanked pixels are black even when straddled
            if (!(ce.lhbl && ce.lvbl)) begin
                ce.col  = '0;
                ce.skip = 1'b0;
            end
            if (!ce.skip) begin
                check_colour("red", red, ce.col.red);
                check_colour("green", green, ce.col.green);
                check_colour("blue", blue, ce.col.blue);
            end
        end
        if (!rst && pxl_cen) begin
            pix_cnt++;
        end
    end

    // Run limit
    always @(posedge clk) begin
        clk_cnt++;
        if (clk_cnt >= TIMEOUT) begin
            $display("Timeout after %0d clocks, the stimulus did not finish", clk_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== project.f ====
+incdir+include
source/video_timing_pkg.sv
source/colour_pkg.sv
source/video_timing.sv
source/palette_ram.sv
source/colour_mixer.sv
source/blank_delay.sv
source/video_colour_top.sv
bench/clock_gen.sv
bench/video_colour_tb.sv

// ==== Bender.yml ====
package:
  name: video_colour

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/video_timing_pkg.sv
      - source/colour_pkg.sv
      - source/video_timing.sv
      - source/palette_ram.sv
      - source/colour_mixer.sv
      - source/blank_delay.sv
      - source/video_colour_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/clock_gen.sv
      - bench/video_colour_tb.sv
